// File: src/datapathPkg.sv
package datapathPkg;

        typedef logic [31:0] wordT;     // bus and register width
        typedef logic [63:0] dwordT;    // full alu result
        typedef logic [3:0] regIdxT;    // general register index
        typedef logic [4:0] busSelT;    // encoded bus source
        typedef logic [4:0] aluOpT;

        // ====================
        // alu operation codes
        localparam aluOpT opAdd = 5'd3;
        localparam aluOpT opSub = 5'd4;
        localparam aluOpT opAnd = 5'd5;
        localparam aluOpT opOr = 5'd6;
        localparam aluOpT opShr = 5'd7;
        localparam aluOpT opShra = 5'd8;
        localparam aluOpT opShl = 5'd9;
        localparam aluOpT opRor = 5'd10;
        localparam aluOpT opRol = 5'd11;
        localparam aluOpT opMul = 5'd12;
        localparam aluOpT opNeg = 5'd13;
        localparam aluOpT opNot = 5'd14;

        // ====================
        // bus sources, lowest number has priority
        localparam busSelT srcR0 = 5'd0;
        localparam busSelT srcR1 = 5'd1;
        localparam busSelT srcR2 = 5'd2;
        localparam busSelT srcR3 = 5'd3;
        localparam busSelT srcR4 = 5'd4;
        localparam busSelT srcR5 = 5'd5;
        localparam busSelT srcR6 = 5'd6;
        localparam busSelT srcR7 = 5'd7;
        localparam busSelT srcR8 = 5'd8;
        localparam busSelT srcR9 = 5'd9;
        localparam busSelT srcR10 = 5'd10;
        localparam busSelT srcR11 = 5'd11;
        localparam busSelT srcR12 = 5'd12;
        localparam busSelT srcR13 = 5'd13;
        localparam busSelT srcR14 = 5'd14;
        localparam busSelT srcR15 = 5'd15;
        localparam busSelT srcHi = 5'd16;
        localparam busSelT srcLo = 5'd17;
        localparam busSelT srcZHigh = 5'd18;
        localparam busSelT srcZLow = 5'd19;
        localparam busSelT srcPc = 5'd20;
        localparam busSelT srcMdr = 5'd21;

endpackage

// File: src/busMux.sv
module busMux
        import datapathPkg::*;
(
        input logic [15:0] rOut,
        input logic HIout,
        input logic LOout,
        input logic ZHighout,
        input logic ZLowout,
        input logic PCout,
        input logic MDRout,
        input wordT regWords [16],
        input wordT hiWord,
        input wordT loWord,
        input wordT zHighWord,
        input wordT zLowWord,
        input wordT pcWord,
        input wordT mdrWord,
        output wordT busData
);

        logic [21:0] outStrobes;        // indexed by busSelT value
        busSelT busSel;
        logic busActive;
        regIdxT regSel;

        assign outStrobes = {MDRout, PCout, ZLowout, ZHighout, LOout, HIout, rOut};
        assign regSel = regIdxT'(busSel);

        // ====================
        // priority encoder
        always_comb begin
                busSel = srcR0;
                busActive = 1'b0;
                // scan downward so the lowest set strobe is kept
                for (int i = 21; i >= 0; i--) begin
                        if (outStrobes[i]) begin
                                busSel = busSelT'(i);
                                busActive = 1'b1;
                        end
                end
        end

        // ====================
        // source select
        always_comb begin
                busData = '0;   // idle bus
                if (busActive) begin
                        case (busSel)
                                srcHi: busData = hiWord;
                                srcLo: busData = loWord;
                                srcZHigh: busData = zHighWord;
                                srcZLow: busData = zLowWord;
                                srcPc: busData = pcWord;
                                srcMdr: busData = mdrWord;
                                default: busData = regWords[regSel];
                        endcase
                end
        end

endmodule

// File: src/registerFile.sv
module registerFile
        import datapathPkg::*;
(
        input logic Clock,
        input logic rstN,
        input logic [15:0] rIn,
        input wordT busData,
        output wordT regWords [16]
);

        // ====================
        // general registers R0 to R15
        for (genvar g = 0; g < 16; g++) begin : genReg
                always_ff @(posedge Clock or negedge rstN) begin
                        if (!rstN) begin
                                regWords[g] <= '0;
                        end else if (rIn[g]) begin
                                regWords[g] <= busData;   // own in-strobe only
                        end
                end
        end

endmodule

// File: src/mdrUnit.sv
module mdrUnit
        import datapathPkg::*;
(
        input logic Clock,
        input logic rstN,
        input logic MDRin,
        input logic Read,
        input wordT busData,
        input wordT memData,
        output wordT mdrWord
);

        wordT mdrNext;

        // memory side wins while Read is high
        assign mdrNext = Read ? memData : busData;

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        mdrWord <= '0;
                end else if (MDRin) begin
                        mdrWord <= mdrNext;
                end
        end

endmodule

// File: src/alu.sv
module alu
        import datapathPkg::*;
(
        input wordT yWord,
        input wordT busData,
        input aluOpT operation,
        input logic IncPC,
        output dwordT result
);

        logic [4:0] shiftAmt;
        dwordT rotWide;         // Y doubled for rotates
        dwordT rorWide;
        dwordT rolWide;
        wordT shraWord;
        logic signed [63:0] product;

        assign shiftAmt = busData[4:0];         // only low 5 bits count
        assign rotWide = {yWord, yWord};
        assign rorWide = rotWide >> shiftAmt;
        assign rolWide = rotWide << shiftAmt;
        assign shraWord = $signed(yWord) >>> shiftAmt;
        assign product = $signed({{32{yWord[31]}}, yWord})
                * $signed({{32{busData[31]}}, busData});

        // ====================
        // operation select
        always_comb begin
                result = '0;
                if (IncPC) begin
                        result[31:0] = busData + 32'd4;         // opcode ignored
                end else begin
                        case (operation)
                                opAdd: result[31:0] = yWord + busData;
                                opSub: result[31:0] = yWord - busData;
                                opAnd: result[31:0] = yWord & busData;
                                opOr: result[31:0] = yWord | busData;
                                opShr: result[31:0] = yWord >> shiftAmt;
                                opShra: result[31:0] = shraWord;
                                opShl: result[31:0] = yWord << shiftAmt;
                                opRor: result[31:0] = rorWide[31:0];
                                opRol: result[31:0] = rolWide[63:32];
                                opMul: result = dwordT'(product);       // full 64 bits
                                opNeg: result[31:0] = 32'd0 - busData;
                                opNot: result[31:0] = ~busData;
                                default: result = '0;
                        endcase
                end
        end

endmodule

// File: src/datapath.sv
module datapath
        import datapathPkg::*;
(
        input logic Clock,
        input logic rstN,
        input logic [15:0] rOut,
        input logic [15:0] rIn,
        input logic HIout,
        input logic LOout,
        input logic ZHighout,
        input logic ZLowout,
        input logic PCout,
        input logic MDRout,
        input logic HIin,
        input logic LOin,
        input logic Zin,
        input logic PCin,
        input logic IRin,
        input logic Yin,
        input logic MARin,
        input logic MDRin,
        input logic Read,
        input logic IncPC,
        input aluOpT operation,
        input wordT memData,
        output wordT busData,
        output wordT memAddress,
        output wordT irWord
);

        wordT regWords [16];
        wordT pcWord;
        wordT yWord;
        wordT hiWord;
        wordT loWord;
        wordT zHighWord;
        wordT zLowWord;
        wordT mdrWord;
        dwordT aluResult;

        // ====================
        // bus
        busMux uBusMux (
                .rOut(rOut),
                .HIout(HIout),
                .LOout(LOout),
                .ZHighout(ZHighout),
                .ZLowout(ZLowout),
                .PCout(PCout),
                .MDRout(MDRout),
                .regWords(regWords),
                .hiWord(hiWord),
                .loWord(loWord),
                .zHighWord(zHighWord),
                .zLowWord(zLowWord),
                .pcWord(pcWord),
                .mdrWord(mdrWord),
                .busData(busData)
        );

        registerFile uRegisterFile (
                .Clock(Clock),
                .rstN(rstN),
                .rIn(rIn),
                .busData(busData),
                .regWords(regWords)
        );

        mdrUnit uMdrUnit (
                .Clock(Clock),
                .rstN(rstN),
                .MDRin(MDRin),
                .Read(Read),
                .busData(busData),
                .memData(memData),
                .mdrWord(mdrWord)
        );

        alu uAlu (
                .yWord(yWord),
                .busData(busData),
                .operation(operation),
                .IncPC(IncPC),
                .result(aluResult)
        );

        // ====================
        // special registers, all bus loaded
        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        pcWord <= '0;
                        irWord <= '0;
                        yWord <= '0;
                        memAddress <= '0;
                        hiWord <= '0;
                        loWord <= '0;
                end else begin
                        if (PCin) pcWord <= busData;
                        if (IRin) irWord <= busData;
                        if (Yin) yWord <= busData;      // first alu operand
                        if (MARin) memAddress <= busData;
                        if (HIin) hiWord <= busData;
                        if (LOin) loWord <= busData;
                end
        end

        // ====================
        // Z takes both halves of the alu result
        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        zHighWord <= '0;
                        zLowWord <= '0;
                end else if (Zin) begin
                        zHighWord <= aluResult[63:32];
                        zLowWord <= aluResult[31:0];
                end
        end

endmodule

// File: sim/datapath_props.sv
module datapathProps
        import datapathPkg::*;
(
        input logic Clock,
        input logic rstN,
        input logic Zin,
        input logic IncPC,
        input logic [15:0] rIn,
        input wordT busData,
        input wordT zLowWord,
        input wordT regWords [16]
);

        // ====================
        // Z after an IncPC cycle
        assert property (@(posedge Clock) disable iff (!rstN)
                (Zin && IncPC) |=> zLowWord == $past(busData) + 32'd4)
                else $error("ZLow is not the earlier bus value plus 4");

        // ====================
        // general registers
        for (genvar g = 0; g < 16; g++) begin : genRegProps
                assert property (@(posedge Clock) disable iff (!rstN)
                        !rIn[g] |=> regWords[g] == $past(regWords[g]))
                        else $error("register %0d changed without its in-strobe", g);

                assert property (@(posedge Clock) $rose(rstN) |-> regWords[g] == '0)
                        else $error("register %0d not zero after reset", g);
        end

endmodule

bind datapath datapathProps uProps (
        .Clock(Clock),
        .rstN(rstN),
        .Zin(Zin),
        .IncPC(IncPC),
        .rIn(rIn),
        .busData(busData),
        .zLowWord(zLowWord),
        .regWords(regWords)
);

// File: sim/datapathTb.sv
module datapathTb
        import datapathPkg::*;
();

        localparam int numTests = 37;   // 4 load, 28 alu, 2 pc, 2 ir, 1 priority

        logic Clock;
        logic rstN;
        logic [15:0] rOut;
        logic [15:0] rIn;
        logic HIout, LOout, ZHighout, ZLowout, PCout, MDRout;
        logic HIin, LOin, Zin, PCin, IRin, Yin, MARin, MDRin;
        logic Read;
        logic IncPC;
        aluOpT operation;
        wordT memData;
        wordT busData;
        wordT memAddress;
        wordT irWord;

        wordT rngState = 32'd90437;
        logic checkOn;
        int checkSel;           // 0 bus, 1 memAddress, 2 irWord
        string checkName;
        wordT expWord;
        int errorCount = 0;
        int checkCount = 0;

        datapath UUT (.*);

        initial begin
                Clock = 1'b0;
                forever #20 Clock = ~Clock;
        end

        // ====================
        // reference model and random source
        function automatic wordT xorshift(input wordT s);
                wordT x;
                x = s;
                x ^= x << 13;
                x ^= x >> 17;
                x ^= x << 5;
                return x;
        endfunction

        function wordT nextRandom();
                rngState = xorshift(rngState);
                return rngState;
        endfunction

        function automatic dwordT expectedResult(input aluOpT op, input wordT yVal,
                        input wordT bVal, input logic incPc);
                int n;
                longint a;
                longint b;
                dwordT r;
                n = int'(bVal[4:0]);
                a = longint'($signed(yVal));
                b = longint'($signed(bVal));
                r = '0;
                if (incPc) begin
                        r = {32'd0, bVal + 32'd4};
                end else begin
                        case (op)
                                opAdd: r[31:0] = yVal + bVal;
                                opSub: r[31:0] = yVal - bVal;
                                opAnd: r[31:0] = yVal & bVal;
                                opOr: r[31:0] = yVal | bVal;
                                opShr: r[31:0] = yVal >> n;
                                opShra: r[31:0] = wordT'($signed(yVal) >>> n);
                                opShl: r[31:0] = yVal << n;
                                opRor: r[31:0] = (n == 0) ? yVal : (yVal >> n) | (yVal << (32 - n));
                                opRol: r[31:0] = (n == 0) ? yVal : (yVal << n) | (yVal >> (32 - n));
                                opMul: r = dwordT'(a * b);
                                opNeg: r[31:0] = 32'd0 - bVal;
                                opNot: r[31:0] = ~bVal;
                                default: r = '0;
                        endcase
                end
                return r;
        endfunction

        // ====================
        // comparing process, mid-cycle
        function automatic wordT observed(input int sel);
                case (sel)
                        0: return busData;
                        1: return memAddress;
                        default: return irWord;
                endcase
        endfunction

        always @(negedge Clock) begin
                wordT seen;
                if (checkOn) begin
                        seen = observed(checkSel);
                        checkCount++;
                        assert (seen == expWord) else begin
                                $display("CHECK FAILED %s: got %h, expected %h",
                                        checkName, seen, expWord);
                                errorCount++;
                        end
                end
        end

        // ====================
        // stimulus helpers
        task automatic clearControls();
                rOut = '0;
                rIn = '0;
                {HIout, LOout, ZHighout, ZLowout, PCout, MDRout} = '0;
                {HIin, LOin, Zin, PCin, IRin, Yin, MARin, MDRin} = '0;
                Read = 1'b0;
                IncPC = 1'b0;
                operation = '0;
                memData = '0;
                checkOn = 1'b0;
        endtask

        task automatic step();
                @(posedge Clock);
                #5;
                clearControls();
        endtask

        task automatic expectValue(input int sel, input string name, input wordT value);
                checkSel = sel;
                checkName = name;
                expWord = value;
                checkOn = 1'b1;
        endtask

        task automatic loadRegister(input regIdxT idx, input wordT value);
                step();
                memData = value;
                Read = 1'b1;
                MDRin = 1'b1;
                step();
                MDRout = 1'b1;
                rIn[idx] = 1'b1;
        endtask

        // ====================
        // test sequences
        task automatic memoryLoad();
                wordT w;
                wordT v;
                regIdxT r;
                w = nextRandom();
                v = nextRandom();
                r = w[3:0];
                loadRegister(r, v);
                step();
                rOut[r] = 1'b1;
                expectValue(0, "busData (register)", v);
        endtask

        task automatic aluCase(input aluOpT op, input wordT a, input wordT b);
                wordT w;
                regIdxT ia;
                regIdxT ib;
                dwordT want;
                w = nextRandom();
                ia = w[3:0];
                ib = ia ^ (w[7:4] | 4'b0001);   // never equal to ia
                want = expectedResult(op, a, b, 1'b0);
                loadRegister(ia, a);
                loadRegister(ib, b);
                step();
                rOut[ia] = 1'b1;
                Yin = 1'b1;
                step();
                rOut[ib] = 1'b1;
                operation = op;
                Zin = 1'b1;
                step();
                ZLowout = 1'b1;
                expectValue(0, "busData (ZLow)", want[31:0]);
                step();
                ZHighout = 1'b1;
                expectValue(0, "busData (ZHigh)", want[63:32]);
        endtask

        task automatic pcIncrement();
                wordT w;
                wordT v;
                regIdxT r;
                dwordT want;
                w = nextRandom();
                v = nextRandom();
                r = w[3:0];
                want = expectedResult(opAdd, '0, v, 1'b1);
                loadRegister(r, v);
                step();
                rOut[r] = 1'b1;
                PCin = 1'b1;
                step();
                PCout = 1'b1;
                IncPC = 1'b1;
                Zin = 1'b1;
                MARin = 1'b1;
                step();
                ZLowout = 1'b1;
                PCin = 1'b1;
                step();
                expectValue(1, "memAddress", v);
                step();
                PCout = 1'b1;
                expectValue(0, "busData (PC)", want[31:0]);
        endtask

        task automatic mdrToIr();
                wordT w;
                wordT v;
                regIdxT r;
                w = nextRandom();
                v = nextRandom();
                r = w[3:0];
                loadRegister(r, v);
                step();
                memData = ~v;           // MDR starts away from v
                Read = 1'b1;
                MDRin = 1'b1;
                step();
                rOut[r] = 1'b1;
                MDRin = 1'b1;
                memData = ~v;           // must be ignored, Read low
                step();
                MDRout = 1'b1;
                IRin = 1'b1;
                step();
                expectValue(2, "irWord", v);
        endtask

        task automatic busPriority();
                wordT w;
                wordT va;
                wordT vb;
                regIdxT ra;
                regIdxT rb;
                w = nextRandom();
                va = nextRandom();
                vb = nextRandom();
                ra = {1'b0, w[2:0]};
                rb = {1'b1, w[6:4]};
                step();
                expectValue(0, "busData (idle)", 32'd0);
                loadRegister(ra, va);
                loadRegister(rb, vb);   // MDR now holds vb
                step();
                rOut[ra] = 1'b1;
                rOut[rb] = 1'b1;
                expectValue(0, "busData (two registers)", va);
                step();
                rOut[ra] = 1'b1;
                HIin = 1'b1;
                step();
                HIout = 1'b1;
                MDRout = 1'b1;
                expectValue(0, "busData (HI over MDR)", va);
        endtask

        // ====================
        // main sequence
        initial begin
                wordT w;
                rstN = 1'b0;
                clearControls();
                checkSel = 0;
                expWord = '0;
                repeat (4) @(posedge Clock);
                #5 rstN = 1'b1;
                repeat (4) memoryLoad();
                for (int k = 3; k <= 14; k++) begin
                        repeat (2) aluCase(aluOpT'(k), nextRandom(), nextRandom());
                end
                w = nextRandom();
                aluCase(opRor, nextRandom(), {w[31:5], 5'd0});
                aluCase(opRor, nextRandom(), {w[31:5], 5'd31});
                aluCase(opRol, nextRandom(), {w[31:5], 5'd0});
                aluCase(opRol, nextRandom(), {w[31:5], 5'd31});
                repeat (2) pcIncrement();
                repeat (2) mdrToIr();
                busPriority();
                step();
                $display("%0d errors in %0d checks", errorCount, checkCount);
                if (errorCount == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        initial begin
                repeat (400 + 40 * numTests) @(posedge Clock);
                $display("Timeout: the test sequence did not finish in %0d cycles",
                        400 + 40 * numTests);
                $display("Errors found");
                $finish;
        end

endmodule

// File: tb.f
src/datapathPkg.sv
src/busMux.sv
src/registerFile.sv
src/mdrUnit.sv
src/alu.sv
src/datapath.sv
sim/datapath_props.sv
sim/datapathTb.sv

// File: run.sh
#!/bin/sh
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f tb.f --top-module datapathTb -o datapathSim
output=$(./obj_dir/datapathSim || true)
echo "$output"
echo "$output" | grep -q "No errors"
